// File: rtl/sdPkg.sv
// SD card SPI host shared definitions

package sdPkg;

   ////////////////////////////////////////
   // Data widths
   ////////////////////////////////////////

   // Byte on the SPI data path
   typedef logic [7:0]  byte_t;
   // SD command index
   typedef logic [5:0]  cmdIndex_t;
   // SD command argument
   typedef logic [31:0] cmdArg_t;
   // CRC7 remainder
   typedef logic [6:0]  crc7_t;
   // Serial clock divisor count
   typedef logic [5:0]  clkDiv_t;

   ////////////////////////////////////////
   // Constants
   ////////////////////////////////////////

   // Slow divisor for card initialization
   localparam clkDiv_t slowDiv = 6'd63;
   // Fast divisor for normal transfers
   localparam clkDiv_t fastDiv = 6'd1;
   // Response bytes read before timeout
   localparam int respPolls = 8;

   ////////////////////////////////////////
   // Encodings
   ////////////////////////////////////////

   // Engine opcodes
   typedef enum logic [2:0]
   {
      opNop  = 3'd0,
      opCsl  = 3'd1,
      opCsh  = 3'd2,
      opFast = 3'd3,
      opSlow = 3'd4,
      opTr   = 3'd5
   } spiOp_t;

   // Engine states
   typedef enum logic [2:0]
   {
      phyReset,
      phyIdle,
      phyClkLow,
      phyClkHigh,
      phyLastHigh,
      phyLastLow
   } phyState_t;

   // Sequencer states
   typedef enum logic [2:0]
   {
      cmdIdle,
      cmdSpeed,
      cmdSelect,
      cmdFrame,
      cmdPoll,
      cmdDeselect,
      cmdTrail,
      cmdFinish
   } cmdState_t;

endpackage

// File: rtl/sdCrc7.sv
// Bytewise CRC7 for SD command frames

`timescale 1ns/1ps

module sdCrc7
(
   input  logic           clk,
   input  logic           rst,
   input  logic           crcClear,
   input  logic           crcEnable,
   input  sdPkg::byte_t   crcData,
   output sdPkg::crc7_t   crc
);

   // Running remainder
   sdPkg::crc7_t crcReg;
   // Remainder after folding crcData
   sdPkg::crc7_t crcNext;
   // Serial feedback bit
   logic feedback;

   // Eight serial steps of x^7 + x^3 + 1
   always_comb
   begin
      crcNext  = crcReg;
      feedback = 1'b0;
      for (int i = 7; i >= 0; i--)
      begin
         // MSB first
         feedback = crcNext[6] ^ crcData[i];
         crcNext  = {crcNext[5:0], 1'b0} ^ (feedback ? 7'h09 : 7'h00);
      end
   end

   // Clear wins over enable
   always_ff @(posedge clk)
   begin
      if (rst || crcClear)
         crcReg <= '0;
      else if (crcEnable)
         crcReg <= crcNext;
   end

   assign crc = crcReg;

endmodule

// File: rtl/sdSpiPhy.sv
// SD card SPI physical engine
// Byte transfers on a divided serial clock

`timescale 1ns/1ps

module sdSpiPhy
(
   input  logic            clk,
   input  logic            rst,
   input  sdPkg::spiOp_t   spiOp,
   input  sdPkg::byte_t    spiTxd,
   output sdPkg::byte_t    spiRxd,
   output logic            spiDone,
   input  logic            spiMiso,
   output logic            spiMosi,
   output logic            spiSclk,
   output logic            spiCs
);

   // Engine state
   sdPkg::phyState_t state;
   // Cycles left in the current phase
   sdPkg::clkDiv_t phaseCnt;
   // Active divisor
   sdPkg::clkDiv_t clkDiv;
   // Bits left in the byte
   logic [2:0] bitCnt;
   // Transmit and receive shifters
   sdPkg::byte_t txShift;
   sdPkg::byte_t rxShift;

   ////////////////////////////////////////
   // Transfer state machine
   ////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state    <= sdPkg::phyReset;
         phaseCnt <= '0;
         clkDiv   <= sdPkg::slowDiv;
         bitCnt   <= '0;
         txShift  <= 8'hFF;
         rxShift  <= 8'hFF;
         spiDone  <= 1'b0;
         spiCs    <= 1'b1;
      end
      else
      begin
         case (state)
            // One settling cycle with ops ignored
            sdPkg::phyReset:
            begin
               clkDiv <= sdPkg::slowDiv;
               state  <= sdPkg::phyIdle;
            end

            // Decode the next op
            sdPkg::phyIdle:
            begin
               spiDone <= 1'b0;
               case (spiOp)
                  sdPkg::opCsl:
                     spiCs <= 1'b0;
                  sdPkg::opCsh:
                     spiCs <= 1'b1;
                  sdPkg::opFast:
                     clkDiv <= sdPkg::fastDiv;
                  sdPkg::opSlow:
                     clkDiv <= sdPkg::slowDiv;
                  sdPkg::opTr:
                  begin
                     // Load byte and start with MSB low phase
                     phaseCnt <= clkDiv;
                     bitCnt   <= 3'd7;
                     txShift  <= spiTxd;
                     state    <= sdPkg::phyClkLow;
                  end
                  default:
                     state <= sdPkg::phyIdle;
               endcase
            end

            // SCLK low
            sdPkg::phyClkLow:
            begin
               if (phaseCnt == '0)
               begin
                  // Sample MISO at the end of the low phase
                  phaseCnt <= clkDiv;
                  rxShift  <= {rxShift[6:0], spiMiso};
                  state    <= sdPkg::phyClkHigh;
               end
               else
                  phaseCnt <= phaseCnt - 1'b1;
            end

            // SCLK high
            sdPkg::phyClkHigh:
            begin
               if (phaseCnt == '0)
               begin
                  phaseCnt <= clkDiv;
                  if (bitCnt == '0)
                     state <= sdPkg::phyLastHigh;
                  else
                  begin
                     // Next bit onto MOSI and ones fill behind
                     txShift <= {txShift[6:0], 1'b1};
                     bitCnt  <= bitCnt - 1'b1;
                     state   <= sdPkg::phyClkLow;
                  end
               end
               else
                  phaseCnt <= phaseCnt - 1'b1;
            end

            // Hold after the last bit
            sdPkg::phyLastHigh:
            begin
               if (phaseCnt == '0)
               begin
                  phaseCnt <= clkDiv;
                  state    <= sdPkg::phyLastLow;
               end
               else
                  phaseCnt <= phaseCnt - 1'b1;
            end

            // Final phase then done
            sdPkg::phyLastLow:
            begin
               if (phaseCnt == '0)
               begin
                  phaseCnt <= clkDiv;
                  spiDone  <= 1'b1;
                  state    <= sdPkg::phyIdle;
               end
               else
                  phaseCnt <= phaseCnt - 1'b1;
            end

            default:
               state <= sdPkg::phyIdle;
         endcase
      end
   end

   // Serial clock drops only in the low phase of each bit
   assign spiSclk = (state != sdPkg::phyClkLow);
   assign spiMosi = txShift[7];
   assign spiRxd  = rxShift;

endmodule

// File: rtl/sdCommand.sv
// SD command sequencer
// Frame out and R1 poll over the SPI engine

`timescale 1ns/1ps

module sdCommand
(
   input  logic               clk,
   input  logic               rst,
   // Request side
   input  logic               cmdStart,
   input  logic               cmdFast,
   input  sdPkg::cmdIndex_t   cmdIndex,
   input  sdPkg::cmdArg_t     cmdArg,
   output logic               cmdDone,
   output logic               cmdBusy,
   output sdPkg::byte_t       cmdR1,
   output logic               cmdTimeout,
   // SPI engine
   output sdPkg::spiOp_t      spiOp,
   output sdPkg::byte_t       spiTxd,
   input  sdPkg::byte_t       spiRxd,
   input  logic               spiDone,
   // CRC unit
   output logic               crcClear,
   output logic               crcEnable,
   output sdPkg::byte_t       crcData,
   input  sdPkg::crc7_t       crc
);

   sdPkg::cmdState_t state;

   // Latched request
   logic             fastReg;
   sdPkg::cmdIndex_t indexReg;
   sdPkg::cmdArg_t   argReg;

   // Op issued and now waiting on it
   logic opSent;
   // Frame byte number
   logic [2:0] byteCnt;
   // Response bytes read so far
   logic [3:0] pollCnt;
   // Current frame byte
   sdPkg::byte_t frameByte;

   ////////////////////////////////////////
   // Frame byte select
   ////////////////////////////////////////

   always_comb
   begin
      case (byteCnt)
         3'd0:    frameByte = {2'b01, indexReg};
         3'd1:    frameByte = argReg[31:24];
         3'd2:    frameByte = argReg[23:16];
         3'd3:    frameByte = argReg[15:8];
         3'd4:    frameByte = argReg[7:0];
         // CRC with end bit
         3'd5:    frameByte = {crc, 1'b1};
         default: frameByte = 8'hFF;
      endcase
   end

   ////////////////////////////////////////
   // Transaction state machine
   ////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      // Strobes default low
      spiOp     <= sdPkg::opNop;
      crcClear  <= 1'b0;
      crcEnable <= 1'b0;
      if (rst)
      begin
         state      <= sdPkg::cmdIdle;
         opSent     <= 1'b0;
         byteCnt    <= '0;
         pollCnt    <= '0;
         cmdR1      <= 8'hFF;
         cmdTimeout <= 1'b0;
      end
      else
      begin
         case (state)
            // Accept a request and start a fresh CRC
            sdPkg::cmdIdle:
            begin
               if (cmdStart)
               begin
                  fastReg  <= cmdFast;
                  indexReg <= cmdIndex;
                  argReg   <= cmdArg;
                  crcClear <= 1'b1;
                  opSent   <= 1'b0;
                  state    <= sdPkg::cmdSpeed;
               end
            end

            // Pick clock speed then wait one cycle
            sdPkg::cmdSpeed:
            begin
               if (!opSent)
               begin
                  spiOp  <= fastReg ? sdPkg::opFast : sdPkg::opSlow;
                  opSent <= 1'b1;
               end
               else
               begin
                  opSent <= 1'b0;
                  state  <= sdPkg::cmdSelect;
               end
            end

            // Chip select low then wait one cycle
            sdPkg::cmdSelect:
            begin
               if (!opSent)
               begin
                  spiOp  <= sdPkg::opCsl;
                  opSent <= 1'b1;
               end
               else
               begin
                  opSent  <= 1'b0;
                  byteCnt <= '0;
                  state   <= sdPkg::cmdFrame;
               end
            end

            // Six command bytes
            sdPkg::cmdFrame:
            begin
               if (!opSent)
               begin
                  spiOp     <= sdPkg::opTr;
                  spiTxd    <= frameByte;
                  // CRC covers bytes 0 to 4 only
                  crcEnable <= (byteCnt != 3'd5);
                  crcData   <= frameByte;
                  opSent    <= 1'b1;
               end
               else if (spiDone)
               begin
                  opSent <= 1'b0;
                  if (byteCnt == 3'd5)
                  begin
                     pollCnt <= '0;
                     state   <= sdPkg::cmdPoll;
                  end
                  else
                     byteCnt <= byteCnt + 1'b1;
               end
            end

            // Clock 0xFF until R1 shows up or polls run out
            sdPkg::cmdPoll:
            begin
               if (!opSent)
               begin
                  spiOp  <= sdPkg::opTr;
                  spiTxd <= 8'hFF;
                  opSent <= 1'b1;
               end
               else if (spiDone)
               begin
                  opSent  <= 1'b0;
                  cmdR1   <= spiRxd;
                  pollCnt <= pollCnt + 1'b1;
                  if (!spiRxd[7])
                  begin
                     // Start bit of R1 is zero
                     cmdTimeout <= 1'b0;
                     state      <= sdPkg::cmdDeselect;
                  end
                  else if (pollCnt == 4'(sdPkg::respPolls - 1))
                  begin
                     cmdTimeout <= 1'b1;
                     state      <= sdPkg::cmdDeselect;
                  end
               end
            end

            // Chip select high then wait one cycle
            sdPkg::cmdDeselect:
            begin
               if (!opSent)
               begin
                  spiOp  <= sdPkg::opCsh;
                  opSent <= 1'b1;
               end
               else
               begin
                  opSent <= 1'b0;
                  state  <= sdPkg::cmdTrail;
               end
            end

            // Eight clocks with the card released
            sdPkg::cmdTrail:
            begin
               if (!opSent)
               begin
                  spiOp  <= sdPkg::opTr;
                  spiTxd <= 8'hFF;
                  opSent <= 1'b1;
               end
               else if (spiDone)
               begin
                  opSent <= 1'b0;
                  state  <= sdPkg::cmdFinish;
               end
            end

            // Done cycle
            sdPkg::cmdFinish:
               state <= sdPkg::cmdIdle;

            default:
               state <= sdPkg::cmdIdle;
         endcase
      end
   end

   // Status straight from the state
   assign cmdDone = (state == sdPkg::cmdFinish);
   assign cmdBusy = (state != sdPkg::cmdIdle);

endmodule

// File: rtl/sdSpiHost.sv
// SD card SPI host top level

`timescale 1ns/1ps

module sdSpiHost
(
   input  logic               clk,
   input  logic               rst,
   input  logic               cmdStart,
   input  logic               cmdFast,
   input  sdPkg::cmdIndex_t   cmdIndex,
   input  sdPkg::cmdArg_t     cmdArg,
   output logic               cmdDone,
   output logic               cmdBusy,
   output sdPkg::byte_t       cmdR1,
   output logic               cmdTimeout,
   input  logic               spiMiso,
   output logic               spiMosi,
   output logic               spiSclk,
   output logic               spiCs
);

   // Sequencer to engine
   sdPkg::spiOp_t spiOp;
   sdPkg::byte_t  spiTxd;
   sdPkg::byte_t  spiRxd;
   logic          spiDone;

   // Sequencer to CRC
   logic          crcClear;
   logic          crcEnable;
   sdPkg::byte_t  crcData;
   sdPkg::crc7_t  crc;

   sdCommand iCommand
   (
      .clk        (clk),
      .rst        (rst),
      .cmdStart   (cmdStart),
      .cmdFast    (cmdFast),
      .cmdIndex   (cmdIndex),
      .cmdArg     (cmdArg),
      .cmdDone    (cmdDone),
      .cmdBusy    (cmdBusy),
      .cmdR1      (cmdR1),
      .cmdTimeout (cmdTimeout),
      .spiOp      (spiOp),
      .spiTxd     (spiTxd),
      .spiRxd     (spiRxd),
      .spiDone    (spiDone),
      .crcClear   (crcClear),
      .crcEnable  (crcEnable),
      .crcData    (crcData),
      .crc        (crc)
   );

   sdCrc7 iCrc7
   (
      .clk       (clk),
      .rst       (rst),
      .crcClear  (crcClear),
      .crcEnable (crcEnable),
      .crcData   (crcData),
      .crc       (crc)
   );

   sdSpiPhy iSpiPhy
   (
      .clk     (clk),
      .rst     (rst),
      .spiOp   (spiOp),
      .spiTxd  (spiTxd),
      .spiRxd  (spiRxd),
      .spiDone (spiDone),
      .spiMiso (spiMiso),
      .spiMosi (spiMosi),
      .spiSclk (spiSclk),
      .spiCs   (spiCs)
   );

endmodule

// File: verification/sdCardModel.sv
// Behavioral SD card on SPI

`timescale 1ns/1ps

module sdCardModel
(
   input  logic          spiSclk,
   input  logic          spiCs,
   input  logic          spiMosi,
   output logic          spiMiso,
   // Response programming
   input  int            respDelay,
   input  sdPkg::byte_t  respR1,
   // Observed traffic
   output logic [47:0]   frameBytes,
   output int            frameCount,
   output int            csHighEdges
);

   // Previous pin levels for edge detection
   logic         csLast    = 1'b1;
   logic         sclkLast  = 1'b1;
   logic         misoReg   = 1'b1;
   // First six bytes of the selection, byte 0 on top
   logic [47:0]  frameReg  = '1;
   int           selects   = 0;
   int           idleEdges = 0;
   // Bytes finished since select
   int           byteNum   = 0;
   int           inBit     = 0;
   int           outBit    = 0;
   sdPkg::byte_t inShift   = 8'hFF;
   sdPkg::byte_t outByte   = 8'hFF;

   // Idle ones until R1 is due
   function automatic sdPkg::byte_t replyByte(input int n);
      if (n == 6 + respDelay)
         return respR1;
      return 8'hFF;
   endfunction

   ////////////////////////////////////////
   // Pin activity
   ////////////////////////////////////////

   always @(spiSclk or spiCs)
   begin
      if (spiCs === 1'b0 && csLast === 1'b1)
      begin
         // New selection
         selects   = selects + 1;
         idleEdges = 0;
         byteNum   = 0;
         inBit     = 0;
         outBit    = 0;
      end
      else if (spiSclk === 1'b1 && sclkLast === 1'b0)
      begin
         if (spiCs === 1'b1)
            idleEdges = idleEdges + 1;
         else if (spiCs === 1'b0)
         begin
            // Command bits arrive MSB first
            inShift = {inShift[6:0], spiMosi};
            inBit   = inBit + 1;
            if (inBit == 8)
            begin
               if (byteNum < 6)
                  frameReg[47 - 8 * byteNum -: 8] = inShift;
               byteNum = byteNum + 1;
               inBit   = 0;
            end
         end
      end
      else if (spiSclk === 1'b0 && sclkLast === 1'b1 && spiCs === 1'b0)
      begin
         // Next response bit on the falling edge
         if (outBit == 0)
            outByte = replyByte(byteNum);
         misoReg = outByte[7 - outBit];
         outBit  = (outBit + 1) % 8;
      end
      // Released card idles high
      if (spiCs === 1'b1)
         misoReg = 1'b1;
      csLast   = spiCs;
      sclkLast = spiSclk;
   end

   assign spiMiso     = misoReg;
   assign frameBytes  = frameReg;
   assign frameCount  = selects;
   assign csHighEdges = idleEdges;

endmodule

// File: verification/sdSpiHost_checker.sv
// SPI pin and strobe assertions

`timescale 1ns/1ps

module sdSpiHost_checker
(
   input  logic   clk,
   input  logic   rst,
   input  logic   cmdDone,
   input  logic   cmdBusy,
   input  logic   spiSclk,
   input  logic   spiCs
);

   // Card stays deselected out of reset
   csAfterReset: assert property (@(posedge clk) rst |=> spiCs)
      else $error("spiCs low in the cycle after reset");

   // Done is a single-cycle strobe
   doneSingle: assert property (@(posedge clk) disable iff (rst) cmdDone |=> !cmdDone)
      else $error("cmdDone high for two cycles in a row");

   // Idle bus parks SCLK high
   sclkIdleHigh: assert property (@(posedge clk) disable iff (rst)
      (spiCs && !cmdBusy) |-> spiSclk)
      else $error("spiSclk low while deselected and idle");

endmodule

bind sdSpiHost sdSpiHost_checker i_checker
(
   .clk     (clk),
   .rst     (rst),
   .cmdDone (cmdDone),
   .cmdBusy (cmdBusy),
   .spiSclk (spiSclk),
   .spiCs   (spiCs)
);

// File: verification/sdSpiHost_tb.sv
// SD card SPI host testbench

`timescale 1ns/1ps

module sdSpiHost_tb;

   // 20 commands of 8 bytes with 18 phases of up to 64 cycles
   localparam int    cycleLimit = 20 * 8 * 18 * 64;
   localparam string dataPath   = "verification/sdSpiHost_testdata.txt";

   // Request side
   logic             clk;
   logic             rst;
   logic             cmdStart;
   logic             cmdFast;
   sdPkg::cmdIndex_t cmdIndex;
   sdPkg::cmdArg_t   cmdArg;
   logic             cmdDone;
   logic             cmdBusy;
   sdPkg::byte_t     cmdR1;
   logic             cmdTimeout;
   // SPI pins
   logic             spiMiso;
   logic             spiMosi;
   logic             spiSclk;
   logic             spiCs;
   // Card model
   int               respDelay;
   sdPkg::byte_t     respR1;
   logic [47:0]      frameBytes;
   int               frameCount;
   int               csHighEdges;
   // Run bookkeeping
   int               cycleCount;
   int               doneCount;
   int               lowWidth;
   int               expLowWidth;

   sdSpiHost i_dut
   (
      .clk        (clk),
      .rst        (rst),
      .cmdStart   (cmdStart),
      .cmdFast    (cmdFast),
      .cmdIndex   (cmdIndex),
      .cmdArg     (cmdArg),
      .cmdDone    (cmdDone),
      .cmdBusy    (cmdBusy),
      .cmdR1      (cmdR1),
      .cmdTimeout (cmdTimeout),
      .spiMiso    (spiMiso),
      .spiMosi    (spiMosi),
      .spiSclk    (spiSclk),
      .spiCs      (spiCs)
   );

   sdCardModel iCard
   (
      .spiSclk     (spiSclk),
      .spiCs       (spiCs),
      .spiMosi     (spiMosi),
      .spiMiso     (spiMiso),
      .respDelay   (respDelay),
      .respR1      (respR1),
      .frameBytes  (frameBytes),
      .frameCount  (frameCount),
      .csHighEdges (csHighEdges)
   );

   // 100 ns period
   always #50 clk = ~clk;

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   task automatic abortRun(input string reason);
      $display("%s", reason);
      $display("TEST FAILED");
      $fatal(1, "Simulation stopped on first error");
   endtask

   // Message times x^7 modulo x^7 + x^3 + 1 by long division
   function automatic sdPkg::crc7_t crc7Of(input logic [39:0] message);
      logic [46:0] dividend;
      dividend = {message, 7'b0};
      for (int i = 46; i >= 7; i--)
      begin
         if (dividend[i])
            dividend[i -: 8] = dividend[i -: 8] ^ 8'h89;
      end
      return dividend[6:0];
   endfunction

   ////////////////////////////////////////
   // Monitors
   ////////////////////////////////////////

   // Run limit
   always @(posedge clk)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= cycleLimit)
         abortRun("Timeout: cycle limit reached before all commands finished");
   end

   always @(posedge clk)
   begin
      if (!rst && cmdDone === 1'b1)
         doneCount <= doneCount + 1;
   end

   // Width of every SCLK low phase in clock cycles
   always @(posedge clk)
   begin
      if (!rst && spiSclk === 1'b0)
         lowWidth <= lowWidth + 1;
      else if (lowWidth != 0)
      begin
         assert (lowWidth == expLowWidth)
         else abortRun($sformatf("[FAIL] spiSclk low width: got 0x%0h expected 0x%0h",
            lowWidth, expLowWidth));
         lowWidth <= 0;
      end
   end

   ////////////////////////////////////////
   // One command transaction
   ////////////////////////////////////////

   task automatic runCommand(input logic fast, input sdPkg::cmdIndex_t index,
      input sdPkg::cmdArg_t arg, input int delay, input sdPkg::byte_t r1, input logic expTo);
      int           framesBefore;
      int           donesBefore;
      int           waitCycles;
      logic         seenDone;
      logic [39:0]  message;
      logic [47:0]  expFrame;
      sdPkg::byte_t expR1;
      framesBefore = frameCount;
      donesBefore  = doneCount;
      message      = {8'h40 | {2'b00, index}, arg};
      expFrame     = {message, crc7Of(message), 1'b1};
      expR1        = expTo ? 8'hFF : r1;
      // Program card and issue the request
      @(posedge clk);
      respDelay   <= delay;
      respR1      <= r1;
      expLowWidth <= fast ? int'(sdPkg::fastDiv) + 1 : int'(sdPkg::slowDiv) + 1;
      cmdFast     <= fast;
      cmdIndex    <= index;
      cmdArg      <= arg;
      cmdStart    <= 1'b1;
      @(posedge clk);
      cmdStart <= 1'b0;
      assert (cmdBusy === 1'b0)
      else abortRun($sformatf("[FAIL] cmdBusy: got 0x%0h expected 0x0", cmdBusy));
      waitCycles = 0;
      seenDone   = 1'b0;
      while (!seenDone)
      begin
         @(posedge clk);
         waitCycles++;
         assert (cmdBusy === 1'b1)
         else abortRun($sformatf("[FAIL] cmdBusy: got 0x%0h expected 0x1", cmdBusy));
         if (cmdDone === 1'b1)
            seenDone = 1'b1;
         else if (waitCycles == 10)
         begin
            // Stray request while busy
            cmdStart <= 1'b1;
            cmdFast  <= ~fast;
            cmdIndex <= ~index;
            cmdArg   <= ~arg;
         end
         else if (waitCycles == 11)
            cmdStart <= 1'b0;
      end
      // Results of the done cycle
      assert (cmdTimeout === expTo)
      else abortRun($sformatf("[FAIL] cmdTimeout: got 0x%0h expected 0x%0h", cmdTimeout, expTo));
      assert (cmdR1 === expR1)
      else abortRun($sformatf("[FAIL] cmdR1: got 0x%02h expected 0x%02h", cmdR1, expR1));
      assert (spiCs === 1'b1)
      else abortRun($sformatf("[FAIL] spiCs: got 0x%0h expected 0x1", spiCs));
      assert (csHighEdges == 8)
      else abortRun($sformatf("[FAIL] csHighEdges: got 0x%0h expected 0x8", csHighEdges));
      for (int b = 0; b < 6; b++)
      begin
         assert (frameBytes[47 - 8 * b -: 8] === expFrame[47 - 8 * b -: 8])
         else abortRun($sformatf("[FAIL] frameBytes[%0d]: got 0x%02h expected 0x%02h", b,
            frameBytes[47 - 8 * b -: 8], expFrame[47 - 8 * b -: 8]));
      end
      // Stray request left no trace
      repeat (4) @(posedge clk);
      assert (doneCount == donesBefore + 1)
      else abortRun($sformatf("[FAIL] doneCount: got 0x%0h expected 0x%0h",
         doneCount, donesBefore + 1));
      assert (frameCount == framesBefore + 1)
      else abortRun($sformatf("[FAIL] frameCount: got 0x%0h expected 0x%0h",
         frameCount, framesBefore + 1));
      assert (cmdBusy === 1'b0)
      else abortRun($sformatf("[FAIL] cmdBusy: got 0x%0h expected 0x0", cmdBusy));
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial
   begin
      int          fd;
      int          code;
      int          delay;
      int          tests;
      string       line;
      logic [31:0] fast;
      logic [31:0] index;
      logic [31:0] arg;
      logic [31:0] r1;
      logic [31:0] expTo;
      clk         = 1'b0;
      rst         = 1'b1;
      cmdStart    = 1'b0;
      cmdFast     = 1'b0;
      cmdIndex    = '0;
      cmdArg      = '0;
      respDelay   = 0;
      respR1      = 8'hFF;
      cycleCount  = 0;
      doneCount   = 0;
      lowWidth    = 0;
      expLowWidth = int'(sdPkg::slowDiv) + 1;
      tests       = 0;
      // Three reset cycles
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      fd = $fopen(dataPath, "r");
      if (fd == 0)
         abortRun("Could not open the test data file");
      while (!$feof(fd))
      begin
         code = $fgets(line, fd);
         if (code == 0)
            break;
         // Skip comments and blank lines
         if (line.len() < 2 || line.getc(0) == "#")
            continue;
         code = $sscanf(line, "%d %h %h %d %h %d", fast, index, arg, delay, r1, expTo);
         if (code != 6)
            abortRun("Malformed line in the test data file");
         runCommand(fast[0], index[5:0], arg, delay, r1[7:0], expTo[0]);
         tests++;
      end
      $fclose(fd);
      assert (tests > 0 && doneCount == tests)
      begin
         $display("TEST OK");
         $finish;
      end
      else
         abortRun("Command count does not match the test data file");
   end

endmodule

// File: sdCard.f
rtl/sdPkg.sv
rtl/sdCrc7.sv
rtl/sdSpiPhy.sv
rtl/sdCommand.sv
rtl/sdSpiHost.sv
verification/sdCardModel.sv
verification/sdSpiHost_checker.sv
verification/sdSpiHost_tb.sv

// File: runSim.sh
#!/bin/sh
# Build and run the SD card SPI host simulation with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module sdSpiHost_tb -f sdCard.f \
   && ./obj_dir/VsdSpiHost_tb > sim.log 2>&1
grep -qx "TEST OK" sim.log && echo "Simulation passed" && exit 0 \
   || { echo "Simulation failed, see sim.log"; exit 1; }

// File: verification/sdSpiHost_testdata.txt
# fast index(hex) arg(hex) delay r1(hex) expTimeout
# delay counts idle bytes before R1, 8 or more leaves the card silent
0 00 00000000 0 01 0
1 08 000001AA 1 01 0
1 37 00000000 2 01 0
1 29 40000000 3 00 0
1 11 00001000 7 00 0
1 18 0000ABCD 8 ff 1
1 3F FFFFFFFF 0 7F 0
1 0D 12345678 5 04 0
0 10 00000200 1 00 0
0 3A DEADBEEF 9 05 1
1 01 A5A55A5A 4 05 0
1 2A 00000000 12 00 1
0 17 87654321 7 7E 0
1 09 00010000 6 09 0
1 3B 0F0F0F0F 0 00 0
